//--- common/csr_pkg.sv
// csr shared definitions

`default_nettype none

package csr_pkg;

  // one machine word
  typedef logic [31:0] word_t;

  // csr address space is 12 bits
  typedef logic [11:0] csr_addr_t;

  // rs1 index or zimm, same instruction field
  typedef logic [4:0] reg_idx_t;

  // matches funct3 of the zicsr instructions
  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSRRW    = 3'd1,
    CSRRS    = 3'd2,
    CSRRC    = 3'd3,
    CSRRWI   = 3'd5,
    CSRRSI   = 3'd6,
    CSRRCI   = 3'd7
  } csr_op_t;

  // machine mode csr addresses
  localparam csr_addr_t ADDR_MSTATUS       = 12'h300;
  localparam csr_addr_t ADDR_MISA          = 12'h301;
  localparam csr_addr_t ADDR_MTVEC         = 12'h305;
  localparam csr_addr_t ADDR_MCOUNTINHIBIT = 12'h320;
  localparam csr_addr_t ADDR_MSCRATCH      = 12'h340;
  localparam csr_addr_t ADDR_MEPC          = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE        = 12'h342;

  // counters, low and high halves
  localparam csr_addr_t ADDR_MCYCLE        = 12'hB00;
  localparam csr_addr_t ADDR_MCYCLEH       = 12'hB80;
  localparam csr_addr_t ADDR_MINSTRET      = 12'hB02;
  localparam csr_addr_t ADDR_MINSTRETH     = 12'hB82;

  // mstatus bit positions
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

endpackage

`default_nettype wire

//--- csr_file/csr.sv
// single control and status register

`default_nettype none

module csr #(
  parameter int unsigned csr_width = 32,
  parameter logic [csr_width-1:0] reset_value = '0,
  parameter csr_pkg::csr_addr_t addr = '0,
  parameter bit readable = 1'b1,
  parameter bit writable = 1'b1
) (
  input logic clk,
  input logic reset,
  input logic csr_enable,
  input csr_pkg::csr_addr_t csr_addr,
  input csr_pkg::csr_op_t csr_op,
  input csr_pkg::reg_idx_t rs1_zimm,
  input csr_pkg::word_t rs1_data,
  // side-effect write, wins over software
  input logic [csr_width-1:0] ext_data,
  input logic ext_write_enable,
  output csr_pkg::word_t out
);
  import csr_pkg::*;

  logic [csr_width-1:0] data_q;
  word_t operand;
  logic [csr_width-1:0] src;
  logic hit;

  assign hit = (csr_addr == addr);

  // immediate forms take zimm, zero extended
  assign operand = (csr_op inside {CSRRWI, CSRRSI, CSRRCI}) ? word_t'(rs1_zimm) : rs1_data;
  assign src = operand[csr_width-1:0];

  // combinational read, old value
  assign out = (readable && hit) ? word_t'(data_q) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      data_q <= reset_value;
    end else if (ext_write_enable) begin
      data_q <= ext_data;
    end else if (csr_enable && hit && writable) begin
      case (csr_op)
        CSRRW, CSRRWI: begin
          data_q <= src;
        end
        // x0 or zimm 0 means read only
        CSRRS, CSRRSI: begin
          if (rs1_zimm != '0) begin
            data_q <= data_q | src;
          end
        end
        CSRRC, CSRRCI: begin
          if (rs1_zimm != '0) begin
            data_q <= data_q & ~src;
          end
        end
        default: ;
      endcase
    end
  end

  // side-effect strobe must be driven once out of reset
  ext_we_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(ext_write_enable)
  );

endmodule

`default_nettype wire

//--- csr_file/csr_counter.sv
// 64-bit machine counter

`default_nettype none

module csr_counter #(
  parameter csr_pkg::csr_addr_t addr_lo = '0,
  parameter csr_pkg::csr_addr_t addr_hi = '0
) (
  input logic clk,
  input logic reset,
  input logic csr_enable,
  input csr_pkg::csr_addr_t csr_addr,
  input csr_pkg::csr_op_t csr_op,
  input csr_pkg::reg_idx_t rs1_zimm,
  input csr_pkg::word_t rs1_data,
  input logic count_enable,
  output csr_pkg::word_t lo_out,
  output csr_pkg::word_t hi_out
);
  import csr_pkg::*;

  word_t lo_q;
  word_t hi_q;
  word_t lo_next;
  word_t hi_next;
  logic carry;
  logic lo_hit;
  logic hi_hit;

  // address decode local, so the halves always expose their count
  assign lo_hit = (csr_addr == addr_lo);
  assign hi_hit = (csr_addr == addr_hi);

  // both halves step in the same edge
  assign carry = &lo_q;
  assign lo_next = lo_q + 32'd1;
  assign hi_next = hi_q + word_t'(carry);

  // increment owns the ext port, so software lands only while inhibited
  csr #(
    .csr_width  (32),
    .reset_value('0),
    .addr       (addr_lo),
    .readable   (1'b1),
    .writable   (1'b1)
  ) lo_i (
    .clk             (clk),
    .reset           (reset),
    .csr_enable      (csr_enable && lo_hit),
    .csr_addr        (addr_lo),
    .csr_op          (csr_op),
    .rs1_zimm        (rs1_zimm),
    .rs1_data        (rs1_data),
    .ext_data        (lo_next),
    .ext_write_enable(count_enable),
    .out             (lo_q)
  );

  csr #(
    .csr_width  (32),
    .reset_value('0),
    .addr       (addr_hi),
    .readable   (1'b1),
    .writable   (1'b1)
  ) hi_i (
    .clk             (clk),
    .reset           (reset),
    .csr_enable      (csr_enable && hi_hit),
    .csr_addr        (addr_hi),
    .csr_op          (csr_op),
    .rs1_zimm        (rs1_zimm),
    .rs1_data        (rs1_data),
    .ext_data        (hi_next),
    .ext_write_enable(count_enable),
    .out             (hi_q)
  );

  // read path, zero on a miss
  assign lo_out = lo_hit ? lo_q : '0;
  assign hi_out = hi_hit ? hi_q : '0;

endmodule

`default_nettype wire

//--- csr_file/csr_file.sv
// machine mode csr file

`default_nettype none

module csr_file #(
  parameter csr_pkg::word_t misa_value = 32'h4000_0100,
  parameter csr_pkg::word_t mtvec_reset = 32'h0000_0100
) (
  input logic clk,
  input logic reset,
  input logic csr_enable,
  input csr_pkg::csr_addr_t csr_addr,
  input csr_pkg::csr_op_t csr_op,
  input csr_pkg::reg_idx_t rs1_zimm,
  input csr_pkg::word_t rs1_data,
  input logic retire,
  input csr_pkg::word_t ext_mstatus,
  input logic ext_mstatus_we,
  input csr_pkg::word_t ext_mepc,
  input csr_pkg::word_t ext_mcause,
  input logic ext_trap_we,
  output csr_pkg::word_t rd_data,
  output logic illegal,
  output csr_pkg::word_t mstatus_q,
  output csr_pkg::word_t mtvec_q,
  output csr_pkg::word_t mepc_q
);
  import csr_pkg::*;

  // only mie and mpie are implemented
  localparam word_t mstatus_mask = (word_t'(1) << MSTATUS_MIE) | (word_t'(1) << MSTATUS_MPIE);

  logic [10:0] hits;
  logic known;
  logic write_intent;
  word_t mstatus_raw;
  word_t misa_out;
  word_t inhibit_word;
  word_t mscratch_out;
  word_t mcause_out;
  word_t cycle_lo;
  word_t cycle_hi;
  word_t instret_lo;
  word_t instret_hi;

  // one bit per implemented address
  assign hits = {
    csr_addr == ADDR_MSTATUS,  csr_addr == ADDR_MISA,     csr_addr == ADDR_MTVEC,
    csr_addr == ADDR_MCOUNTINHIBIT, csr_addr == ADDR_MSCRATCH, csr_addr == ADDR_MEPC,
    csr_addr == ADDR_MCAUSE,   csr_addr == ADDR_MCYCLE,   csr_addr == ADDR_MCYCLEH,
    csr_addr == ADDR_MINSTRET, csr_addr == ADDR_MINSTRETH
  };
  assign known = |hits;

  // set and clear with x0 or zimm 0 are pure reads
  always_comb begin
    case (csr_op)
      CSRRW, CSRRWI: write_intent = 1'b1;
      CSRRS, CSRRC, CSRRSI, CSRRCI: write_intent = (rs1_zimm != '0);
      default: write_intent = 1'b0;
    endcase
  end

  // misa sits at hits[9]
  assign illegal = csr_enable && (!known || (write_intent && hits[9]));

  // registers feeding the trap logic see their own address, decode is here
  csr #(.csr_width(32), .reset_value('0), .addr(ADDR_MSTATUS)) mstatus_i (
    .clk, .reset, .csr_enable(csr_enable && hits[10]), .csr_addr(ADDR_MSTATUS),
    .csr_op, .rs1_zimm, .rs1_data, .ext_data(ext_mstatus),
    .ext_write_enable(ext_mstatus_we), .out(mstatus_raw)
  );
  assign mstatus_q = mstatus_raw & mstatus_mask;

  csr #(.csr_width(32), .reset_value(misa_value), .addr(ADDR_MISA), .writable(1'b0)) misa_i (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .rs1_zimm, .rs1_data,
    .ext_data('0), .ext_write_enable(1'b0), .out(misa_out)
  );

  csr #(.csr_width(32), .reset_value(mtvec_reset), .addr(ADDR_MTVEC)) mtvec_i (
    .clk, .reset, .csr_enable(csr_enable && hits[8]), .csr_addr(ADDR_MTVEC),
    .csr_op, .rs1_zimm, .rs1_data, .ext_data('0), .ext_write_enable(1'b0), .out(mtvec_q)
  );

  // bit 0 cycle, bit 2 instret
  csr #(.csr_width(3), .reset_value('0), .addr(ADDR_MCOUNTINHIBIT)) mcountinhibit_i (
    .clk, .reset, .csr_enable(csr_enable && hits[7]), .csr_addr(ADDR_MCOUNTINHIBIT),
    .csr_op, .rs1_zimm, .rs1_data, .ext_data(3'b000), .ext_write_enable(1'b0),
    .out(inhibit_word)
  );

  csr #(.csr_width(32), .reset_value('0), .addr(ADDR_MSCRATCH)) mscratch_i (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .rs1_zimm, .rs1_data,
    .ext_data('0), .ext_write_enable(1'b0), .out(mscratch_out)
  );

  csr #(.csr_width(32), .reset_value('0), .addr(ADDR_MEPC)) mepc_i (
    .clk, .reset, .csr_enable(csr_enable && hits[5]), .csr_addr(ADDR_MEPC),
    .csr_op, .rs1_zimm, .rs1_data, .ext_data(ext_mepc), .ext_write_enable(ext_trap_we),
    .out(mepc_q)
  );

  csr #(.csr_width(32), .reset_value('0), .addr(ADDR_MCAUSE)) mcause_i (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .rs1_zimm, .rs1_data,
    .ext_data(ext_mcause), .ext_write_enable(ext_trap_we), .out(mcause_out)
  );

  csr_counter #(.addr_lo(ADDR_MCYCLE), .addr_hi(ADDR_MCYCLEH)) cycle_i (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .rs1_zimm, .rs1_data,
    .count_enable(!inhibit_word[0]), .lo_out(cycle_lo), .hi_out(cycle_hi)
  );

  csr_counter #(.addr_lo(ADDR_MINSTRET), .addr_hi(ADDR_MINSTRETH)) instret_i (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .rs1_zimm, .rs1_data,
    .count_enable(retire && !inhibit_word[2]), .lo_out(instret_lo), .hi_out(instret_hi)
  );

  // misses read zero, so a plain or merges
  assign rd_data = (hits[10] ? mstatus_q : '0) | misa_out | (hits[8] ? mtvec_q : '0)
                 | (hits[7] ? inhibit_word : '0) | mscratch_out | (hits[5] ? mepc_q : '0)
                 | mcause_out | cycle_lo | cycle_hi | instret_lo | instret_hi;

  // address map has no aliases
  addr_unique: assert property (@(posedge clk) disable iff (reset) $onehot0(hits));

endmodule

`default_nettype wire

//--- source/csr_trap.sv
// trap entry and mret side effects

`default_nettype none

module csr_trap (
  input logic clk,
  input logic trap,
  input csr_pkg::word_t trap_pc,
  input csr_pkg::word_t trap_cause,
  input logic mret,
  input csr_pkg::word_t mstatus_q,
  input csr_pkg::word_t mtvec_q,
  input csr_pkg::word_t mepc_q,
  output csr_pkg::word_t ext_mstatus,
  output logic ext_mstatus_we,
  output csr_pkg::word_t ext_mepc,
  output csr_pkg::word_t ext_mcause,
  output logic ext_trap_we,
  output csr_pkg::word_t trap_vector,
  output csr_pkg::word_t ret_pc
);
  import csr_pkg::*;

  // mstatus interrupt enable stack
  always_comb begin
    ext_mstatus = mstatus_q;
    if (trap) begin
      // push mie into mpie, disable
      ext_mstatus[MSTATUS_MPIE] = mstatus_q[MSTATUS_MIE];
      ext_mstatus[MSTATUS_MIE] = 1'b0;
    end else if (mret) begin
      // pop
      ext_mstatus[MSTATUS_MIE] = mstatus_q[MSTATUS_MPIE];
      ext_mstatus[MSTATUS_MPIE] = 1'b1;
    end
  end
  assign ext_mstatus_we = trap || mret;

  // mepc is word aligned, no compressed support
  assign ext_mepc = {trap_pc[31:2], 2'b00};
  assign ext_mcause = trap_cause;
  assign ext_trap_we = trap;

  // direct mode only, mode bits dropped
  assign trap_vector = {mtvec_q[31:2], 2'b00};
  assign ret_pc = mepc_q;

  // pipeline never retires a trap and an mret together
  trap_mret_excl: assert property (@(posedge clk) !(trap && mret));

endmodule

`default_nettype wire

//--- source/csr_unit.sv
// csr unit top level

`default_nettype none

module csr_unit #(
  parameter csr_pkg::word_t misa_value = 32'h4000_0100,
  parameter csr_pkg::word_t mtvec_reset = 32'h0000_0100
) (
  input logic clk,
  input logic reset,
  // pipeline csr port
  input logic csr_enable,
  input csr_pkg::csr_addr_t csr_addr,
  input csr_pkg::csr_op_t csr_op,
  input csr_pkg::reg_idx_t rs1_zimm,
  input csr_pkg::word_t rs1_data,
  input logic retire,
  input logic trap,
  input csr_pkg::word_t trap_pc,
  input csr_pkg::word_t trap_cause,
  input logic mret,
  output csr_pkg::word_t rd_data,
  output logic illegal,
  output csr_pkg::word_t trap_vector,
  output csr_pkg::word_t ret_pc
);
  import csr_pkg::*;

  // side-effect writes toward the file
  word_t ext_mstatus;
  logic ext_mstatus_we;
  word_t ext_mepc;
  word_t ext_mcause;
  logic ext_trap_we;
  // current values back to trap logic
  word_t mstatus_q;
  word_t mtvec_q;
  word_t mepc_q;

  csr_trap trap_i (
    .clk, .trap, .trap_pc, .trap_cause, .mret,
    .mstatus_q, .mtvec_q, .mepc_q,
    .ext_mstatus, .ext_mstatus_we, .ext_mepc, .ext_mcause, .ext_trap_we,
    .trap_vector, .ret_pc
  );

  csr_file #(.misa_value(misa_value), .mtvec_reset(mtvec_reset)) file_i (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .rs1_zimm, .rs1_data, .retire,
    .ext_mstatus, .ext_mstatus_we, .ext_mepc, .ext_mcause, .ext_trap_we,
    .rd_data, .illegal, .mstatus_q, .mtvec_q, .mepc_q
  );

endmodule

`default_nettype wire

//--- test/csr_unit_tb.sv
// csr unit directed testbench

`default_nettype none

module csr_unit_tb;
  import csr_pkg::*;

  // expected reset contents, same as the dut defaults
  localparam word_t misa_value = 32'h4000_0100;
  localparam word_t mtvec_reset = 32'h0000_0100;
  localparam int poll_limit = 20;

  logic clk;
  logic reset;
  logic csr_enable;
  csr_addr_t csr_addr;
  csr_op_t csr_op;
  reg_idx_t rs1_zimm;
  word_t rs1_data;
  logic retire;
  logic trap;
  word_t trap_pc;
  word_t trap_cause;
  logic mret;
  word_t rd_data;
  logic illegal;
  word_t trap_vector;
  word_t ret_pc;

  // rising edges so far, reference for counter values
  int unsigned edge_count = 0;
  int unsigned sample_edges = 0;
  logic [31:0] lfsr_state = 32'h500b_e0eb;

  csr_unit dut_i (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .rs1_zimm, .rs1_data,
    .retire, .trap, .trap_pc, .trap_cause, .mret,
    .rd_data, .illegal, .trap_vector, .ret_pc
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) edge_count <= edge_count + 1;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one step per bit taken
  task automatic random_bits(input int n, output word_t value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
      $display("TEST FAILED");
      $fatal(1, "%s check failed", name);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("Error: %s", reason);
    $display("TEST FAILED");
    $fatal(1, "%s", reason);
  endtask

  // entered on a falling edge, returns on the next one
  task automatic csr_access(input csr_op_t op, input csr_addr_t addr, input reg_idx_t zimm,
                            input word_t data, output word_t rd, output logic ill);
    csr_enable = 1'b1;
    csr_addr = addr;
    csr_op = op;
    rs1_zimm = zimm;
    rs1_data = data;
    // mid low phase, read path settled
    #2;
    rd = rd_data;
    ill = illegal;
    sample_edges = edge_count;
    @(negedge clk);
    csr_enable = 1'b0;
    csr_op = CSR_NONE;
  endtask

  // csrrs with x0, a pure read
  task automatic expect_read(input string name, input csr_addr_t addr, input word_t expected);
    word_t rd;
    logic ill;
    csr_access(CSRRS, addr, 5'd0, 32'hFFFF_FFFF, rd, ill);
    check(name, rd, expected);
    check("illegal", {31'd0, ill}, 32'd0);
  endtask

  task automatic write_csr(input csr_addr_t addr, input word_t data);
    word_t rd;
    logic ill;
    csr_access(CSRRW, addr, 5'd1, data, rd, ill);
    check("illegal", {31'd0, ill}, 32'd0);
  endtask

  task automatic wait_edges(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
    end
  endtask

  task automatic test_reset_values();
    expect_read("misa", ADDR_MISA, misa_value);
    expect_read("mtvec", ADDR_MTVEC, mtvec_reset);
    expect_read("mscratch", ADDR_MSCRATCH, 32'd0);
    expect_read("mepc", ADDR_MEPC, 32'd0);
    expect_read("mcause", ADDR_MCAUSE, 32'd0);
    expect_read("mstatus", ADDR_MSTATUS, 32'd0);
    expect_read("mcountinhibit", ADDR_MCOUNTINHIBIT, 32'd0);
  endtask

  // one access on mscratch, model follows the zicsr rules
  task automatic mscratch_step(input csr_op_t op, input reg_idx_t idx, input word_t data,
                               inout word_t model);
    word_t rd;
    logic ill;
    word_t operand;
    operand = (op == CSRRWI || op == CSRRSI || op == CSRRCI) ? {27'd0, idx} : data;
    csr_access(op, ADDR_MSCRATCH, idx, data, rd, ill);
    check("mscratch", rd, model);
    check("illegal", {31'd0, ill}, 32'd0);
    case (op)
      CSRRW, CSRRWI: model = operand;
      CSRRS, CSRRSI: model = (idx != 5'd0) ? (model | operand) : model;
      CSRRC, CSRRCI: model = (idx != 5'd0) ? (model & ~operand) : model;
      default: ;
    endcase
  endtask

  task automatic test_mscratch_ops();
    csr_op_t ops [6] = '{CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};
    word_t model;
    word_t data;
    word_t rnd;
    model = '0;
    for (int round = 0; round < 2; round++) begin
      foreach (ops[i]) begin
        random_bits(32, data);
        random_bits(5, rnd);
        mscratch_step(ops[i], rnd[4:0] | 5'd1, data, model);
        // x0 or zimm 0, set and clear must not write
        random_bits(32, data);
        mscratch_step(ops[i], 5'd0, data, model);
      end
    end
    expect_read("mscratch", ADDR_MSCRATCH, model);
  endtask

  task automatic test_illegal();
    word_t rd;
    logic ill;
    word_t data;
    random_bits(32, data);
    csr_access(CSRRW, ADDR_MISA, 5'd3, data, rd, ill);
    check("illegal", {31'd0, ill}, 32'd1);
    expect_read("misa", ADDR_MISA, misa_value);
    csr_access(CSRRS, 12'h7C0, 5'd0, data, rd, ill);
    check("illegal", {31'd0, ill}, 32'd1);
    check("rd_data", rd, 32'd0);
    csr_access(CSRRWI, 12'hB03, 5'd9, data, rd, ill);
    check("illegal", {31'd0, ill}, 32'd1);
    check("rd_data", rd, 32'd0);
    // idle port never flags
    #2;
    check("illegal", {31'd0, illegal}, 32'd0);
    @(negedge clk);
  endtask

  task automatic test_counters();
    word_t rd;
    logic ill;
    word_t hi;
    word_t pulse_bits;
    logic [63:0] expected;
    int unsigned start;
    int tries;
    int n;
    logic done;
    csr_access(CSRRWI, ADDR_MCOUNTINHIBIT, 5'd5, 32'd0, rd, ill);
    expect_read("mcountinhibit", ADDR_MCOUNTINHIBIT, 32'd5);
    write_csr(ADDR_MCYCLE, 32'hFFFF_FFFF);
    write_csr(ADDR_MCYCLEH, 32'd0);
    expect_read("mcycle", ADDR_MCYCLE, 32'hFFFF_FFFF);
    expect_read("mcycleh", ADDR_MCYCLEH, 32'd0);
    // release mcycle, minstret stays held
    csr_access(CSRRCI, ADDR_MCOUNTINHIBIT, 5'd1, 32'd0, rd, ill);
    start = edge_count;
    wait_edges(3);
    done = 1'b0;
    tries = 0;
    while (!done && tries < poll_limit) begin
      csr_access(CSRRS, ADDR_MCYCLEH, 5'd0, 32'd0, rd, ill);
      expected = 64'h0000_0000_FFFF_FFFF + 64'(sample_edges - start);
      check("mcycleh", rd, expected[63:32]);
      done = (rd != 32'd0);
      tries++;
    end
    if (!done) begin
      abort_run("mcycleh never received the carry from mcycle");
    end
    csr_access(CSRRS, ADDR_MCYCLE, 5'd0, 32'd0, rd, ill);
    expected = 64'h0000_0000_FFFF_FFFF + 64'(sample_edges - start);
    check("mcycle", rd, expected[31:0]);
    // minstret near the carry, written while held
    random_bits(32, hi);
    write_csr(ADDR_MINSTRET, 32'hFFFF_FFFE);
    write_csr(ADDR_MINSTRETH, hi);
    expect_read("minstret", ADDR_MINSTRET, 32'hFFFF_FFFE);
    expect_read("minstreth", ADDR_MINSTRETH, hi);
    csr_access(CSRRCI, ADDR_MCOUNTINHIBIT, 5'd4, 32'd0, rd, ill);
    expect_read("mcountinhibit", ADDR_MCOUNTINHIBIT, 32'd0);
    random_bits(2, pulse_bits);
    n = 3 + int'(pulse_bits[1:0]);
    for (int i = 0; i < n; i++) begin
      retire = 1'b1;
      @(negedge clk);
      retire = 1'b0;
      @(negedge clk);
    end
    expected = {hi, 32'hFFFF_FFFE};
    expected = expected + 64'(n);
    expect_read("minstret", ADDR_MINSTRET, expected[31:0]);
    expect_read("minstreth", ADDR_MINSTRETH, expected[63:32]);
  endtask

  task automatic test_trap_mret();
    word_t rd;
    logic ill;
    word_t vec;
    word_t pc;
    word_t cause;
    word_t mie;
    word_t mpie;
    mie = word_t'(1) << MSTATUS_MIE;
    mpie = word_t'(1) << MSTATUS_MPIE;
    random_bits(32, vec);
    write_csr(ADDR_MTVEC, vec);
    expect_read("mtvec", ADDR_MTVEC, vec);
    csr_access(CSRRSI, ADDR_MSTATUS, 5'd8, 32'd0, rd, ill);
    check("illegal", {31'd0, ill}, 32'd0);
    expect_read("mstatus", ADDR_MSTATUS, mie);
    random_bits(32, pc);
    random_bits(32, cause);
    trap = 1'b1;
    trap_pc = pc;
    trap_cause = cause;
    #2;
    check("trap_vector", trap_vector, vec & ~32'h3);
    @(negedge clk);
    trap = 1'b0;
    expect_read("mepc", ADDR_MEPC, pc & ~32'h3);
    expect_read("mcause", ADDR_MCAUSE, cause);
    expect_read("mstatus", ADDR_MSTATUS, mpie);
    mret = 1'b1;
    @(negedge clk);
    mret = 1'b0;
    #2;
    check("ret_pc", ret_pc, pc & ~32'h3);
    @(negedge clk);
    expect_read("mstatus", ADDR_MSTATUS, mie | mpie);
  endtask

  initial begin
    reset = 1'b1;
    csr_enable = 1'b0;
    csr_addr = '0;
    csr_op = CSR_NONE;
    rs1_zimm = '0;
    rs1_data = '0;
    retire = 1'b0;
    trap = 1'b0;
    trap_pc = '0;
    trap_cause = '0;
    mret = 1'b0;
    wait_edges(3);
    reset = 1'b0;
    @(negedge clk);
    test_reset_values();
    test_mscratch_ops();
    test_illegal();
    test_counters();
    test_trap_mret();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
common/csr_pkg.sv
csr_file/csr.sv
csr_file/csr_counter.sv
csr_file/csr_file.sv
source/csr_trap.sv
source/csr_unit.sv
test/csr_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the csr unit testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module csr_unit_tb -o csr_unit_sim

# simulator exit status is not trusted, the log decides
./obj_dir/csr_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
